/* conv_engine.f */
hdl/conv_pkg.sv
hdl/conv_step_if.sv
hdl/conv_ctrl.sv
hdl/kernel_regs.sv
hdl/act_window.sv
hdl/mac_row.sv
hdl/relu_quant.sv
hdl/conv_engine.sv
verification/conv_checker.sv
verification/tb_conv_engine.sv

/* hdl/act_window.sv */
`timescale 1ns/1ns

module act_window import conv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    conv_step_if.dp          step,
    input  act_word_u        act_rdata,
    output logic             win_valid,
    output logic [1:0]       win_krow,
    output logic             win_last,
    output pix_t [win_n-1:0] win
);

    act_word_u word_in;
    act_word_u mid_word;
    pix_t left_px;

    // zero padding replaces the SRAM data
    always_comb begin
        word_in.raw = step.pad ? '0 : act_rdata.raw;
    end

    always_ff @(posedge clk) begin
        if (step.step_valid) begin
            case (step.tap)
                tap_left: begin
                    left_px <= word_in.lane[lanes-1];
                end
                tap_center: begin
                    mid_word <= word_in;
                end
                tap_right: begin
                    win[0] <= left_px;
                    win[lanes:1] <= mid_word.lane;
                    win[win_n-1] <= word_in.lane[0];
                    win_krow <= step.krow;
                    win_last <= step.last;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= step.step_valid && (step.tap == tap_right);
        end
    end

endmodule

/* hdl/conv_ctrl.sv */
`timescale 1ns/1ns

module conv_ctrl import conv_pkg::*; #(
    parameter int img_w = 8,
    parameter int img_h = 4,
    parameter int num_och = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              finish,
    input  logic [addr_w-1:0] weight_offset,
    input  logic [addr_w-1:0] act_offset,
    input  logic [addr_w-1:0] out_offset,
    output logic              weight_en,
    output logic [addr_w-1:0] weight_addr,
    output logic              act_en,
    output logic [addr_w-1:0] act_addr,
    output logic              kw_load,
    output logic [1:0]        kw_row,
    conv_step_if.ctrl         step,
    output logic [addr_w-1:0] out_base,
    output logic              done_pending
);

    localparam logic [addr_w-1:0] wpr = addr_w'(img_w / lanes);
    localparam logic [addr_w-1:0] last_word = addr_w'(img_w / lanes - 1);
    localparam logic [addr_w-1:0] last_row = addr_w'(img_h - 1);
    localparam logic [addr_w-1:0] last_och = addr_w'(num_och - 1);
    // last write lands 4 cycles after the final read, finish 4 after that
    localparam logic [2:0] drain_last = 3'd6;

    typedef enum logic [1:0] {st_idle, st_load, st_conv, st_done} state_t;

    state_t state;
    logic [1:0] wcnt;
    logic [addr_w-1:0] och;
    logic [addr_w-1:0] row;
    logic [addr_w-1:0] word;
    logic [addr_w-1:0] out_idx;
    logic [1:0] krow;
    tap_t tap;
    logic [2:0] drain_cnt;
    logic pad;
    logic word_end;
    logic plane_end;
    logic [addr_w-1:0] in_row;
    logic [addr_w-1:0] in_word;

    assign word_end = (tap == tap_right) && (krow == 2'd2);
    assign plane_end = word_end && (row == last_row) && (word == last_word);

    // neighbor outside the image on any border
    assign pad = ((krow == 2'd0) && (row == '0)) ||
                 ((krow == 2'd2) && (row == last_row)) ||
                 ((tap == tap_left) && (word == '0)) ||
                 ((tap == tap_right) && (word == last_word));

    // wraps below zero only on padded steps, where the address is unused
    assign in_row = row + addr_w'(krow) - 1'b1;
    assign in_word = word + addr_w'(tap) - 1'b1;

    assign act_en = (state == st_conv) && !pad;
    assign act_addr = act_offset + in_row * wpr + in_word;

    assign weight_en = (state == st_load) && (wcnt != 2'd3);
    assign weight_addr = weight_offset + och * addr_w'(ksize) + addr_w'(wcnt);

    assign done_pending = (state == st_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            wcnt <= '0;
            och <= '0;
            row <= '0;
            word <= '0;
            krow <= '0;
            tap <= tap_left;
            out_idx <= '0;
            drain_cnt <= '0;
            finish <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_load;
                        finish <= 1'b0;
                        och <= '0;
                        out_idx <= '0;
                    end
                end
                st_load: begin
                    // three reads then a gap for the last row to land
                    wcnt <= wcnt + 1'b1;
                    if (wcnt == 2'd3) begin
                        state <= st_conv;
                        row <= '0;
                        word <= '0;
                        krow <= '0;
                        tap <= tap_left;
                    end
                end
                st_conv: begin
                    if (tap != tap_right) begin
                        tap <= (tap == tap_left) ? tap_center : tap_right;
                    end else begin
                        tap <= tap_left;
                        if (!word_end) begin
                            krow <= krow + 1'b1;
                        end else begin
                            krow <= '0;
                            out_idx <= out_idx + 1'b1;
                            if (word == last_word) begin
                                word <= '0;
                                row <= row + 1'b1;
                            end else begin
                                word <= word + 1'b1;
                            end
                            if (plane_end) begin
                                if (och == last_och) begin
                                    state <= st_done;
                                end else begin
                                    och <= och + 1'b1;
                                    state <= st_load;
                                end
                            end
                        end
                    end
                end
                st_done: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == drain_last) begin
                        drain_cnt <= '0;
                        finish <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // one cycle late to match SRAM read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step.step_valid <= 1'b0;
            kw_load <= 1'b0;
        end else begin
            step.step_valid <= (state == st_conv);
            kw_load <= weight_en;
        end
    end

    always_ff @(posedge clk) begin
        step.tap <= tap;
        step.krow <= krow;
        step.pad <= pad;
        step.last <= word_end;
        kw_row <= wcnt;
        if ((state == st_conv) && word_end) begin
            out_base <= out_offset + out_idx;
        end
    end

endmodule

/* hdl/conv_engine.sv */
`timescale 1ns/1ns

module conv_engine import conv_pkg::*; #(
    parameter int img_w = 8,
    parameter int img_h = 4,
    parameter int num_och = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     finish,
    input  logic [addr_w-1:0]        weight_offset,
    input  logic [addr_w-1:0]        act_offset,
    input  logic [addr_w-1:0]        out_offset,
    input  logic signed [word_w-1:0] scale,
    output logic                     weight_en,
    output logic [addr_w-1:0]        weight_addr,
    input  logic [word_w-1:0]        weight_rdata,
    output logic                     act_en,
    output logic [addr_w-1:0]        act_addr,
    input  logic [word_w-1:0]        act_rdata,
    output logic                     out_we,
    output logic [addr_w-1:0]        out_addr,
    output logic [word_w-1:0]        out_wdata
);

    logic kw_load;
    logic [1:0] kw_row;
    logic [1:0] sel_row;
    pix_t [ksize-1:0] row_w;
    logic [addr_w-1:0] out_base;
    logic win_valid;
    logic [1:0] win_krow;
    logic win_last;
    pix_t [win_n-1:0] win;
    logic sum_valid;
    acc_t [lanes-1:0] sums;
    logic [addr_w-1:0] sum_addr;

    conv_step_if step_bus ();

    conv_ctrl #(
        .img_w   (img_w),
        .img_h   (img_h),
        .num_och (num_och)
    ) i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .out_offset    (out_offset),
        .weight_en     (weight_en),
        .weight_addr   (weight_addr),
        .act_en        (act_en),
        .act_addr      (act_addr),
        .kw_load       (kw_load),
        .kw_row        (kw_row),
        .step          (step_bus.ctrl),
        .out_base      (out_base),
        .done_pending  ()
    );

    kernel_regs i_kernel (
        .clk          (clk),
        .rst_n        (rst_n),
        .kw_load      (kw_load),
        .kw_row       (kw_row),
        .weight_rdata (weight_rdata),
        .sel_row      (sel_row),
        .row_w        (row_w)
    );

    act_window i_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step_bus.dp),
        .act_rdata (act_rdata),
        .win_valid (win_valid),
        .win_krow  (win_krow),
        .win_last  (win_last),
        .win       (win)
    );

    mac_row i_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .win_valid   (win_valid),
        .win_krow    (win_krow),
        .win_last    (win_last),
        .win         (win),
        .sel_row     (sel_row),
        .row_w       (row_w),
        .out_base_in (out_base),
        .sum_valid   (sum_valid),
        .sums        (sums),
        .sum_addr    (sum_addr)
    );

    relu_quant i_quant (
        .clk       (clk),
        .rst_n     (rst_n),
        .scale     (scale),
        .sum_valid (sum_valid),
        .sums      (sums),
        .sum_addr  (sum_addr),
        .out_we    (out_we),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

endmodule

/* hdl/conv_pkg.sv */
package conv_pkg;

    localparam int word_w = 32;
    localparam int lane_w = 8;
    localparam int lanes = 4;
    localparam int ksize = 3;
    // pixels seen by one output word: one neighbor on each side
    localparam int win_n = lanes + ksize - 1;
    localparam int acc_w = 32;
    localparam int addr_w = 16;

    localparam int quant_lsb = 16;
    localparam int quant_ovf_bit = 23;
    localparam int quant_max = 127;

    typedef logic signed [lane_w-1:0] pix_t;
    typedef logic signed [acc_w-1:0] acc_t;

    typedef enum logic [1:0] {tap_left, tap_center, tap_right} tap_t;

    // lane 0 sits in the low byte
    typedef union packed {
        logic [word_w-1:0] raw;
        pix_t [lanes-1:0] lane;
    } act_word_u;

endpackage

/* hdl/conv_step_if.sv */
`timescale 1ns/1ns

// tags for each activation read, aligned with the returning data
interface conv_step_if import conv_pkg::*; ();

    logic step_valid;
    tap_t tap;
    logic [1:0] krow;
    logic pad;
    logic last;

    modport ctrl (
        output step_valid,
        output tap,
        output krow,
        output pad,
        output last
    );

    modport dp (
        input step_valid,
        input tap,
        input krow,
        input pad,
        input last
    );

endinterface

/* hdl/kernel_regs.sv */
`timescale 1ns/1ns

module kernel_regs import conv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             kw_load,
    input  logic [1:0]       kw_row,
    input  act_word_u        weight_rdata,
    input  logic [1:0]       sel_row,
    output pix_t [ksize-1:0] row_w
);

    pix_t [ksize-1:0] rows_q [ksize];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ksize; i++) begin
                rows_q[i] <= '0;
            end
        end else if (kw_load) begin
            // top lane of each weight word is ignored
            for (int i = 0; i < ksize; i++) begin
                if (kw_row == 2'(i)) begin
                    rows_q[i] <= weight_rdata.lane[ksize-1:0];
                end
            end
        end
    end

    always_comb begin
        row_w = '0;
        for (int i = 0; i < ksize; i++) begin
            if (sel_row == 2'(i)) begin
                row_w = rows_q[i];
            end
        end
    end

endmodule

/* hdl/mac_row.sv */
`timescale 1ns/1ns

module mac_row import conv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              win_valid,
    input  logic [1:0]        win_krow,
    input  logic              win_last,
    input  pix_t [win_n-1:0]  win,
    output logic [1:0]        sel_row,
    input  pix_t [ksize-1:0]  row_w,
    input  logic [addr_w-1:0] out_base_in,
    output logic              sum_valid,
    output acc_t [lanes-1:0]  sums,
    output logic [addr_w-1:0] sum_addr
);

    acc_t dot [lanes];

    assign sel_row = win_krow;

    // output lane j sees window pixels j to j+2
    always_comb begin
        for (int j = 0; j < lanes; j++) begin
            dot[j] = '0;
            for (int k = 0; k < ksize; k++) begin
                dot[j] = dot[j] + win[j+k] * row_w[k];
            end
        end
    end

    // sums double as accumulators, next word's row 0 comes 3 cycles later
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int j = 0; j < lanes; j++) begin
                sums[j] <= (win_krow == 2'd0) ? dot[j] : sums[j] + dot[j];
            end
            if (win_last) begin
                sum_addr <= out_base_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= win_valid && win_last;
        end
    end

endmodule

/* hdl/relu_quant.sv */
`timescale 1ns/1ns

module relu_quant import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic signed [word_w-1:0] scale,
    input  logic                     sum_valid,
    input  acc_t [lanes-1:0]         sums,
    input  logic [addr_w-1:0]        sum_addr,
    output logic                     out_we,
    output logic [addr_w-1:0]        out_addr,
    output act_word_u                out_wdata
);

    acc_t relu [lanes];
    logic signed [2*acc_w-1:0] prod [lanes];
    act_word_u quant_word;

    always_comb begin
        for (int j = 0; j < lanes; j++) begin
            relu[j] = sums[j][acc_w-1] ? '0 : sums[j];
            prod[j] = relu[j] * scale;
            // anything at or above the sign bit of the kept byte saturates
            if (|prod[j][2*acc_w-1:quant_ovf_bit]) begin
                quant_word.lane[j] = pix_t'(quant_max);
            end else begin
                quant_word.lane[j] = prod[j][quant_lsb +: lane_w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_we <= 1'b0;
        end else begin
            out_we <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            out_addr <= sum_addr;
            out_wdata <= quant_word;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the conv_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -Wno-fatal --top-module tb_conv_engine \
    -f conv_engine.f --Mdir obj_dir -o tb_conv_engine
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_conv_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

/* verification/conv_checker.sv */
`timescale 1ns/1ns

module conv_checker #(
    parameter int img_w = 8,
    parameter int img_h = 4,
    parameter int num_och = 2,
    parameter int mem_aw = 6
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               finish,
    input  logic               weight_en,
    input  logic [15:0]        weight_addr,
    input  logic               act_en,
    input  logic [15:0]        act_addr,
    input  logic               out_we,
    input  logic [15:0]        out_addr,
    input  logic [31:0]        out_wdata,
    input  logic [15:0]        weight_offset,
    input  logic [15:0]        act_offset,
    input  logic [15:0]        out_offset,
    input  logic signed [31:0] scale,
    input  logic               rerun,
    input  logic [31:0]        weight_mem [2**mem_aw],
    input  logic [31:0]        act_mem [2**mem_aw],
    output int                 err_count,
    output int                 case_count
);

    localparam int wpr = img_w / 4;
    localparam int plane = img_h * wpr;
    localparam int total = num_och * plane;

    logic [31:0] exp_words [total];
    logic [31:0] prev_out [total];
    int errs = 0;
    int done_cases = 0;
    int case_errs = 0;
    int idx = 0;
    int cyc = 0;
    int last_we_cyc = 0;
    int act_reads = 0;
    int weight_reads = 0;
    int act_base;
    int wt_base;
    int out_base;
    logic signed [31:0] case_scale;
    logic case_rerun = 1'b0;
    logic active = 1'b0;
    logic finish_q = 1'b0;
    logic reset_seen = 1'b0;

    assign err_count = errs;
    assign case_count = done_cases;

    // zero outside the image
    function automatic int pixel_at(input int y, input int x);
        int a;
        logic [31:0] w;
        if (y < 0 || y >= img_h || x < 0 || x >= img_w) begin
            return 0;
        end
        a = act_base + y * wpr + x / 4;
        w = act_mem[a[mem_aw-1:0]];
        return int'($signed(w[8*(x%4) +: 8]));
    endfunction

    function automatic int weight_at(input int o, input int ky, input int kx);
        int a;
        logic [31:0] w;
        a = wt_base + 3 * o + ky;
        w = weight_mem[a[mem_aw-1:0]];
        return int'($signed(w[8*kx +: 8]));
    endfunction

    // nine reads per output word, none for a neighbor word outside the image
    function automatic int in_image_reads();
        int n;
        n = 0;
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < wpr; c++) begin
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        if (r + dy >= 0 && r + dy < img_h && c + dx >= 0 && c + dx < wpr) begin
                            n++;
                        end
                    end
                end
            end
        end
        return num_och * n;
    endfunction

    function automatic logic [7:0] quantize(input int s);
        int pos;
        logic [63:0] p;
        pos = (s < 0) ? 0 : s;
        p = 64'(longint'(pos) * longint'(case_scale));
        if (|p[63:23]) begin
            return 8'd127;
        end
        return p[23:16];
    endfunction

    function automatic logic [31:0] expected_word(input int k);
        int o;
        int r;
        int c;
        int x;
        int s;
        logic [31:0] w;
        o = k / plane;
        r = (k % plane) / wpr;
        c = k % wpr;
        for (int l = 0; l < 4; l++) begin
            x = 4 * c + l;
            s = 0;
            for (int ky = 0; ky < 3; ky++) begin
                for (int kx = 0; kx < 3; kx++) begin
                    s += pixel_at(r + ky - 1, x + kx - 1) * weight_at(o, ky, kx);
                end
            end
            w[8*l +: 8] = quantize(s);
        end
        return w;
    endfunction

    task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("ERROR %s got %h expected %h (case %0d)", sig, got, exp, done_cases);
        errs++;
        case_errs++;
    endtask

    task automatic failure(input string what);
        $display("case %0d: %s", done_cases, what);
        errs++;
        case_errs++;
    endtask

    task automatic begin_case();
        act_base = int'(act_offset);
        wt_base = int'(weight_offset);
        out_base = int'(out_offset);
        case_scale = scale;
        case_rerun = rerun;
        for (int k = 0; k < total; k++) begin
            exp_words[k] = expected_word(k);
        end
        idx = 0;
        case_errs = 0;
        act_reads = 0;
        weight_reads = 0;
        last_we_cyc = cyc;
        active = 1'b1;
    endtask

    // reads stay inside the input plane and the kernels of this case
    task automatic check_reads();
        if (act_en) begin
            act_reads++;
            if (act_addr - 16'(act_base) >= 16'(plane)) begin
                failure($sformatf("activation read at %h outside the input plane", act_addr));
            end
        end
        if (weight_en) begin
            weight_reads++;
            if (weight_addr - 16'(wt_base) >= 16'(3 * num_och)) begin
                failure($sformatf("weight read at %h outside the kernels", weight_addr));
            end
        end
    endtask

    task automatic check_write();
        if (!active || idx >= total) begin
            failure($sformatf("write to %h beyond the %0d expected words", out_addr, total));
        end else begin
            // row-major order, each address once
            if (out_addr != 16'(out_base + idx)) begin
                value_error("out_addr", 32'(out_addr), 32'(out_base + idx));
            end
            if (out_wdata != exp_words[idx]) begin
                value_error("out_wdata", out_wdata, exp_words[idx]);
            end
            if (case_rerun && out_wdata != prev_out[idx]) begin
                value_error("out_wdata against first run", out_wdata, prev_out[idx]);
            end
            prev_out[idx] = out_wdata;
            idx++;
            last_we_cyc = cyc;
        end
    endtask

    task automatic end_case();
        if (!active) begin
            failure("finish rose with no run in progress");
        end else begin
            if (idx != total) begin
                failure($sformatf("%0d writes seen, %0d expected", idx, total));
            end
            if (act_reads != in_image_reads()) begin
                failure($sformatf("%0d activation reads, %0d expected",
                                  act_reads, in_image_reads()));
            end
            if (weight_reads != 3 * num_och) begin
                failure($sformatf("%0d weight reads, %0d expected",
                                  weight_reads, 3 * num_och));
            end
            if (cyc - last_we_cyc != 4) begin
                failure($sformatf("finish rose %0d cycles after the last write, not 4",
                                  cyc - last_we_cyc));
            end
            $display("case %0d: %0d writes, %0d errors", done_cases, idx, case_errs);
            done_cases++;
            active = 1'b0;
        end
    endtask

    // sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_seen = 1'b0;
            finish_q = 1'b0;
            active = 1'b0;
        end else begin
            cyc++;
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (finish) begin
                    value_error("finish", 32'(finish), 32'd0);
                end
                if (out_we) begin
                    value_error("out_we", 32'(out_we), 32'd0);
                end
                if (weight_en) begin
                    value_error("weight_en", 32'(weight_en), 32'd0);
                end
                if (act_en) begin
                    value_error("act_en", 32'(act_en), 32'd0);
                end
            end
            if (start) begin
                begin_case();
            end
            if (active) begin
                check_reads();
            end
            if (out_we) begin
                check_write();
            end
            if (finish && !finish_q) begin
                end_case();
            end
            finish_q = finish;
        end
    end

endmodule

/* verification/tb_conv_engine.sv */
`timescale 1ns/1ns

module tb_conv_engine;

    localparam int img_w = 8;
    localparam int img_h = 4;
    localparam int num_och = 2;
    localparam int mem_aw = 6;
    localparam int mem_depth = 2 ** mem_aw;
    localparam int wpr = img_w / 4;
    localparam int case_limit = num_och * (4 + img_h * wpr * 9) + 50;
    localparam int n_cases = 6;

    localparam logic [1:0] w_rand = 2'd0;
    localparam logic [1:0] w_ones = 2'd1;
    localparam logic [1:0] w_neg = 2'd2;
    localparam logic [1:0] w_max = 2'd3;

    typedef struct packed {
        int         pix_lo;
        int         pix_hi;
        logic [1:0] wpat;
        logic [31:0] scale;
        logic [15:0] woff;
        logic [15:0] aoff;
        logic [15:0] ooff;
        logic       rerun;
    } case_t;

    case_t cases [n_cases];

    logic clk = 1'b0;
    logic rst_n;
    logic start;
    logic [15:0] weight_offset;
    logic [15:0] act_offset;
    logic [15:0] out_offset;
    logic [31:0] scale;
    logic rerun;
    logic finish;
    logic weight_en;
    logic [15:0] weight_addr;
    logic act_en;
    logic [15:0] act_addr;
    logic out_we;
    logic [15:0] out_addr;
    logic [31:0] out_wdata;
    logic [31:0] weight_rdata = '0;
    logic [31:0] act_rdata = '0;
    logic [31:0] weight_mem [mem_depth];
    logic [31:0] act_mem [mem_depth];
    logic [31:0] rng = 32'hc4f6cce4;
    logic timed_out = 1'b0;
    int err_count;
    int case_count;

    always #20 clk = ~clk;

    // both SRAMs answer one cycle after the enable
    always @(posedge clk) begin
        if (weight_en) begin
            weight_rdata <= weight_mem[weight_addr[mem_aw-1:0]];
        end
        if (act_en) begin
            act_rdata <= act_mem[act_addr[mem_aw-1:0]];
        end
    end

    conv_engine #(
        .img_w   (img_w),
        .img_h   (img_h),
        .num_och (num_och)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .out_offset    (out_offset),
        .scale         (scale),
        .weight_en     (weight_en),
        .weight_addr   (weight_addr),
        .weight_rdata  (weight_rdata),
        .act_en        (act_en),
        .act_addr      (act_addr),
        .act_rdata     (act_rdata),
        .out_we        (out_we),
        .out_addr      (out_addr),
        .out_wdata     (out_wdata)
    );

    conv_checker #(
        .img_w   (img_w),
        .img_h   (img_h),
        .num_och (num_och),
        .mem_aw  (mem_aw)
    ) i_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_en     (weight_en),
        .weight_addr   (weight_addr),
        .act_en        (act_en),
        .act_addr      (act_addr),
        .out_we        (out_we),
        .out_addr      (out_addr),
        .out_wdata     (out_wdata),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .out_offset    (out_offset),
        .scale         (scale),
        .rerun         (rerun),
        .weight_mem    (weight_mem),
        .act_mem       (act_mem),
        .err_count     (err_count),
        .case_count    (case_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic fill_memories(input int pix_lo, input int pix_hi, input logic [1:0] wpat);
        logic [31:0] w;
        int span;
        span = pix_hi - pix_lo + 1;
        for (int a = 0; a < mem_depth; a++) begin
            for (int l = 0; l < 4; l++) begin
                rng = xorshift(rng);
                w[8*l +: 8] = 8'(pix_lo + int'(rng % 32'(span)));
            end
            act_mem[a] = w;
            // top lane is junk the engine has to ignore
            w[31:24] = 8'(a) ^ 8'h5a;
            for (int l = 0; l < 3; l++) begin
                rng = xorshift(rng);
                case (wpat)
                    w_rand: w[8*l +: 8] = rng[7:0];
                    w_ones: w[8*l +: 8] = 8'd1;
                    w_neg: w[8*l +: 8] = 8'h80 | rng[7:0];
                    default: w[8*l +: 8] = 8'd127;
                endcase
            end
            weight_mem[a] = w;
        end
    endtask

    task automatic run_case(input int i);
        int cycles;
        if (!cases[i].rerun) begin
            fill_memories(cases[i].pix_lo, cases[i].pix_hi, cases[i].wpat);
        end
        weight_offset = cases[i].woff;
        act_offset = cases[i].aoff;
        out_offset = cases[i].ooff;
        scale = cases[i].scale;
        rerun = cases[i].rerun;
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        cycles = 0;
        while (!finish && cycles < case_limit) begin
            next_cycle();
            cycles++;
        end
        if (!finish) begin
            $display("timeout: case %0d did not finish within %0d cycles", i, case_limit);
            timed_out = 1'b1;
        end
        next_cycle();
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        weight_offset = '0;
        act_offset = '0;
        out_offset = '0;
        scale = '0;
        rerun = 1'b0;
        // pixel lo, pixel hi, weights, scale, weight/act/out offset, rerun
        cases[0] = '{-128, 127, w_rand, 32'h0000_0200, 16'd0, 16'd0, 16'd0, 1'b0};
        cases[1] = '{0, 12, w_ones, 32'h0001_0000, 16'd7, 16'd13, 16'd30, 1'b0};
        cases[2] = '{1, 127, w_neg, 32'h0001_0000, 16'd20, 16'd5, 16'd3, 1'b0};
        cases[3] = '{100, 127, w_max, 32'h0000_8000, 16'd2, 16'd40, 16'd17, 1'b0};
        cases[4] = '{100, 127, w_max, 32'h0000_8000, 16'd2, 16'd40, 16'd17, 1'b1};
        cases[5] = '{-40, 90, w_rand, 32'h0000_0040, 16'd11, 16'd22, 16'd44, 1'b0};
        repeat (16) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        for (int i = 0; i < n_cases && !timed_out; i++) begin
            run_case(i);
        end
        repeat (2) next_cycle();
        $display("%0d of %0d cases finished, %0d errors", case_count, n_cases, err_count);
        if (!timed_out && err_count == 0 && case_count == n_cases) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
